//--- sources.f
+incdir+include
hw/pkt_merge_pkg.sv
hw/pkt_word_if.sv
hw/async_fifo.sv
hw/byte_packer.sv
hw/word_splitter.sv
hw/pkt_merge_arbiter.sv
hw/pkt_merge_top.sv
testbench/pkt_merge_checker.sv
testbench/tb_pkt_merge.sv

//--- testbench/tb_pkt_merge.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_merge
    import pkt_merge_pkg::*;
;

    localparam int NUM_PKTS = 24;
    localparam int MAX_LEN  = 40;

    // one row per packet: test number, channel, length in bytes, idle source clocks before it.
    localparam int STIM [NUM_PKTS][4] = '{
        '{ 1, 0,  1,  4}, '{ 2, 1,  1,  3}, '{ 3, 2,  1,  2},
        '{ 4, 0,  2, 30}, '{ 5, 1,  2, 20}, '{ 6, 2,  2, 20},
        '{ 7, 0,  7, 35}, '{ 8, 1,  3, 22}, '{ 9, 2,  3, 24},
        '{10, 0, 16, 30}, '{11, 1, 10, 25}, '{12, 2,  4, 20},
        '{13, 0, 33, 40}, '{14, 1, 21, 28}, '{15, 2,  5, 22},
        '{16, 0, 40, 45}, '{17, 1, 40, 30}, '{18, 2, 22, 26},
        '{19, 0,  5, 32}, '{20, 1, 17, 24}, '{21, 2, 39, 30},
        '{22, 0, 12, 36}, '{23, 1,  6, 20}, '{24, 2, 40, 30}
    };

    logic        rst_n;
    logic        clk_a;
    logic        clk_b;
    logic        clk_c;
    logic        clk_d;
    logic [7:0]  data_a;
    logic        data_a_sop;
    logic        data_a_eop;
    logic        data_a_vld;
    logic [15:0] data_b;
    logic        data_b_sop;
    logic        data_b_eop;
    logic        data_b_mty;
    logic        data_b_vld;
    logic [31:0] data_c;
    logic        data_c_sop;
    logic        data_c_eop;
    logic [1:0]  data_c_mty;
    logic        data_c_vld;
    logic [15:0] data_d;
    logic        data_d_sop;
    logic        data_d_eop;
    logic        data_d_mty;
    logic        data_d_vld;
    logic [1:0]  chan_d;
    int          test_a;
    int          test_b;
    int          test_c;
    int          n_pass;
    int          n_fail;
    int          n_err;
    logic [7:0]  pkt_bytes [NUM_PKTS][MAX_LEN];

    pkt_merge_top u_pkt_merge_top (
        .rst_n(rst_n),
        .clk_a(clk_a), .data_a(data_a), .data_a_sop(data_a_sop), .data_a_eop(data_a_eop),
        .data_a_vld(data_a_vld),
        .clk_b(clk_b), .data_b(data_b), .data_b_sop(data_b_sop), .data_b_eop(data_b_eop),
        .data_b_mty(data_b_mty), .data_b_vld(data_b_vld),
        .clk_c(clk_c), .data_c(data_c), .data_c_sop(data_c_sop), .data_c_eop(data_c_eop),
        .data_c_mty(data_c_mty), .data_c_vld(data_c_vld),
        .clk_d(clk_d), .data_d(data_d), .data_d_sop(data_d_sop), .data_d_eop(data_d_eop),
        .data_d_mty(data_d_mty), .data_d_vld(data_d_vld), .chan_d(chan_d));

    pkt_merge_checker u_pkt_merge_checker (
        .rst_n(rst_n),
        .clk_a(clk_a), .data_a(data_a), .data_a_sop(data_a_sop), .data_a_eop(data_a_eop),
        .data_a_vld(data_a_vld), .test_a(test_a),
        .clk_b(clk_b), .data_b(data_b), .data_b_sop(data_b_sop), .data_b_eop(data_b_eop),
        .data_b_mty(data_b_mty), .data_b_vld(data_b_vld), .test_b(test_b),
        .clk_c(clk_c), .data_c(data_c), .data_c_sop(data_c_sop), .data_c_eop(data_c_eop),
        .data_c_mty(data_c_mty), .data_c_vld(data_c_vld), .test_c(test_c),
        .clk_d(clk_d), .data_d(data_d), .data_d_sop(data_d_sop), .data_d_eop(data_d_eop),
        .data_d_mty(data_d_mty), .data_d_vld(data_d_vld), .chan_d(chan_d),
        .n_pass(n_pass), .n_fail(n_fail), .n_err(n_err));

    always #10 clk_d = ~clk_d;
    always #7  clk_a = ~clk_a;
    always #13 clk_b = ~clk_b;
    always #17 clk_c = ~clk_c;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1, one step per bit.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // lanes past the end of a packet are zero.
    function automatic logic [7:0] lane_byte(input int r, input int idx);
        if (idx < STIM[r][2]) begin
            return pkt_bytes[r][idx];
        end
        return 8'h00;
    endfunction

    initial begin : init
        logic [15:0] lfsr;
        rst_n      = 1'b0;
        clk_a      = 1'b0;
        clk_b      = 1'b0;
        clk_c      = 1'b0;
        clk_d      = 1'b0;
        data_a     = '0;
        data_a_sop = 1'b0;
        data_a_eop = 1'b0;
        data_a_vld = 1'b0;
        data_b     = '0;
        data_b_sop = 1'b0;
        data_b_eop = 1'b0;
        data_b_mty = 1'b0;
        data_b_vld = 1'b0;
        data_c     = '0;
        data_c_sop = 1'b0;
        data_c_eop = 1'b0;
        data_c_mty = '0;
        data_c_vld = 1'b0;
        test_a     = 0;
        test_b     = 0;
        test_c     = 0;
        lfsr       = 16'd97;
        for (int r = 0; r < NUM_PKTS; r++) begin
            for (int i = 0; i < MAX_LEN; i++) begin
                for (int k = 0; k < 8; k++) begin
                    pkt_bytes[r][i][k] = lfsr[0];
                    lfsr = lfsr_step(lfsr);
                end
            end
        end
        repeat (8) @(posedge clk_d);
        #2;
        rst_n = 1'b1;
    end

    task automatic send_a(input int r);
        int len;
        len = STIM[r][2];
        repeat (STIM[r][3]) @(posedge clk_a);
        for (int i = 0; i < len; i++) begin
            @(posedge clk_a);
            #2;
            test_a     = STIM[r][0];
            data_a     = lane_byte(r, i);
            data_a_sop = (i == 0);
            data_a_eop = (i == len - 1);
            data_a_vld = 1'b1;
        end
        @(posedge clk_a);
        #2;
        data_a     = '0;
        data_a_sop = 1'b0;
        data_a_eop = 1'b0;
        data_a_vld = 1'b0;
    endtask

    task automatic send_b(input int r);
        int len;
        int nw;
        len = STIM[r][2];
        nw  = (len + 1) / 2;
        repeat (STIM[r][3]) @(posedge clk_b);
        for (int w = 0; w < nw; w++) begin
            @(posedge clk_b);
            #2;
            test_b     = STIM[r][0];
            data_b     = {lane_byte(r, 2 * w + 1), lane_byte(r, 2 * w)};
            data_b_sop = (w == 0);
            data_b_eop = (w == nw - 1);
            data_b_mty = (w == nw - 1) ? 1'(2 * nw - len) : 1'b0;
            data_b_vld = 1'b1;
        end
        @(posedge clk_b);
        #2;
        data_b     = '0;
        data_b_sop = 1'b0;
        data_b_eop = 1'b0;
        data_b_mty = 1'b0;
        data_b_vld = 1'b0;
    endtask

    task automatic send_c(input int r);
        int len;
        int nw;
        len = STIM[r][2];
        nw  = (len + 3) / 4;
        repeat (STIM[r][3]) @(posedge clk_c);
        for (int w = 0; w < nw; w++) begin
            @(posedge clk_c);
            #2;
            test_c = STIM[r][0];
            for (int k = 0; k < 4; k++) begin
                data_c[8*k +: 8] = lane_byte(r, 4 * w + k);
            end
            data_c_sop = (w == 0);
            data_c_eop = (w == nw - 1);
            data_c_mty = (w == nw - 1) ? 2'(4 * nw - len) : 2'd0;
            data_c_vld = 1'b1;
        end
        @(posedge clk_c);
        #2;
        data_c     = '0;
        data_c_sop = 1'b0;
        data_c_eop = 1'b0;
        data_c_mty = '0;
        data_c_vld = 1'b0;
    endtask

    // the three channels run at once, each taking its own rows in table order.
    initial begin : drive_a
        wait (rst_n === 1'b1);
        for (int r = 0; r < NUM_PKTS; r++) begin
            if (STIM[r][1] == CHAN_A) begin
                send_a(r);
            end
        end
    end

    initial begin : drive_b
        wait (rst_n === 1'b1);
        for (int r = 0; r < NUM_PKTS; r++) begin
            if (STIM[r][1] == CHAN_B) begin
                send_b(r);
            end
        end
    end

    initial begin : drive_c
        wait (rst_n === 1'b1);
        for (int r = 0; r < NUM_PKTS; r++) begin
            if (STIM[r][1] == CHAN_C) begin
                send_c(r);
            end
        end
    end

    initial begin : watchdog
        longint total;
        total = 0;
        for (int r = 0; r < NUM_PKTS; r++) begin
            total += STIM[r][2];
        end
        #(total * 40 * 20 + 2000);
        $display("timeout: only %0d of %0d packets came out by %0t ns",
                 n_pass + n_fail, NUM_PKTS, $time);
        $display("** FAIL **");
        $finish;
    end

    initial begin : finish_run
        wait (rst_n === 1'b1);
        wait (n_pass + n_fail == NUM_PKTS);
        // stray words after the last packet still reach the checker.
        repeat (50) @(posedge clk_d);
        $display("summary: %0d passed, %0d failed, %0d other errors, %0d packets expected",
                 n_pass, n_fail, n_err, NUM_PKTS);
        if (n_fail == 0 && n_err == 0 && n_pass == NUM_PKTS) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- testbench/pkt_merge_checker.sv
`timescale 1ns/1ns
`default_nettype none

// rebuilds each channel's byte stream from the DUT inputs and checks the merged output.
module pkt_merge_checker
    import pkt_merge_pkg::*;
(
    input  logic        rst_n,
    input  logic        clk_a,
    input  logic [7:0]  data_a,
    input  logic        data_a_sop,
    input  logic        data_a_eop,
    input  logic        data_a_vld,
    input  int          test_a,
    input  logic        clk_b,
    input  logic [15:0] data_b,
    input  logic        data_b_sop,
    input  logic        data_b_eop,
    input  logic        data_b_mty,
    input  logic        data_b_vld,
    input  int          test_b,
    input  logic        clk_c,
    input  logic [31:0] data_c,
    input  logic        data_c_sop,
    input  logic        data_c_eop,
    input  logic [1:0]  data_c_mty,
    input  logic        data_c_vld,
    input  int          test_c,
    input  logic        clk_d,
    input  logic [15:0] data_d,
    input  logic        data_d_sop,
    input  logic        data_d_eop,
    input  logic        data_d_mty,
    input  logic        data_d_vld,
    input  logic [1:0]  chan_d,
    output int          n_pass,
    output int          n_fail,
    output int          n_err
);

    logic [7:0] bytes_a [$];
    logic [7:0] bytes_b [$];
    logic [7:0] bytes_c [$];
    int         lens_a [$];
    int         lens_b [$];
    int         lens_c [$];
    int         tests_a [$];
    int         tests_b [$];
    int         tests_c [$];
    int         cnt_a;
    int         cnt_b;
    int         cnt_c;
    int         sop_test_a;
    int         sop_test_b;
    int         sop_test_c;
    logic       seen_a;
    logic       seen_b;
    logic       seen_c;
    int         rem [3];
    int         words [3];
    int         pkt_len [3];
    int         pkt_test [3];
    logic       pkt_bad [3];
    logic       in_pkt;
    int         cur_ch;

    initial begin
        n_pass = 0;
        n_fail = 0;
        n_err  = 0;
        seen_a = 1'b0;
        seen_b = 1'b0;
        seen_c = 1'b0;
        in_pkt = 1'b0;
        cur_ch = 0;
        for (int i = 0; i < 3; i++) begin
            rem[i]     = 0;
            words[i]   = 0;
            pkt_bad[i] = 1'b0;
        end
    end

    task automatic next_packet(input int ch, output int len, output int test,
                               output logic found);
        found = 1'b0;
        len   = 0;
        test  = 0;
        if (ch == CHAN_A && lens_a.size() > 0) begin
            len  = lens_a.pop_front();
            test = tests_a.pop_front();
        end else if (ch == CHAN_B && lens_b.size() > 0) begin
            len  = lens_b.pop_front();
            test = tests_b.pop_front();
        end else if (ch == CHAN_C && lens_c.size() > 0) begin
            len  = lens_c.pop_front();
            test = tests_c.pop_front();
        end
        found = (len > 0);
    endtask

    task automatic next_byte(input int ch, output logic [7:0] b);
        case (ch)
            CHAN_A:  b = bytes_a.pop_front();
            CHAN_B:  b = bytes_b.pop_front();
            default: b = bytes_c.pop_front();
        endcase
    endtask

    always @(posedge clk_a) begin
        if (rst_n && data_a_vld) begin
            if (data_a_sop) begin
                cnt_a      = 0;
                sop_test_a = test_a;
            end
            bytes_a.push_back(data_a);
            cnt_a++;
            if (data_a_eop) begin
                lens_a.push_back(cnt_a);
                tests_a.push_back(sop_test_a);
                seen_a = 1'b1;
            end
        end
    end

    always @(posedge clk_b) begin : sample_b
        int nb;
        if (rst_n && data_b_vld) begin
            nb = (data_b_eop && data_b_mty) ? 1 : 2;
            if (data_b_sop) begin
                cnt_b      = 0;
                sop_test_b = test_b;
            end
            bytes_b.push_back(data_b[7:0]);
            if (nb == 2) begin
                bytes_b.push_back(data_b[15:8]);
            end
            cnt_b += nb;
            if (data_b_eop) begin
                lens_b.push_back(cnt_b);
                tests_b.push_back(sop_test_b);
                seen_b = 1'b1;
            end
        end
    end

    always @(posedge clk_c) begin : sample_c
        int nb;
        if (rst_n && data_c_vld) begin
            nb = data_c_eop ? 4 - int'(data_c_mty) : 4;
            if (data_c_sop) begin
                cnt_c      = 0;
                sop_test_c = test_c;
            end
            for (int k = 0; k < nb; k++) begin
                bytes_c.push_back(data_c[8*k +: 8]);
            end
            cnt_c += nb;
            if (data_c_eop) begin
                lens_c.push_back(cnt_c);
                tests_c.push_back(sop_test_c);
                seen_c = 1'b1;
            end
        end
    end

    // outputs change on the rising edge, so they are compared on the falling one.
    always @(negedge clk_d) begin : check_out
        int         ch;
        int         len;
        int         test;
        int         take;
        logic       found;
        logic [7:0] lo;
        logic [7:0] hi;
        logic       exp_sop;
        logic       exp_eop;
        logic       exp_mty;
        if (rst_n && data_d_vld) begin
            ch = int'(chan_d);
            if (!(seen_a || seen_b || seen_c)) begin
                $display("output valid at %0t ns before any input packet was complete", $time);
                n_err++;
            end
            if ($isunknown(chan_d) || ch > 2) begin
                $display("output word at %0t ns has unknown channel %b", $time, chan_d);
                n_err++;
            end else begin
                if (in_pkt && ch != cur_ch) begin
                    $display("output word on chan %0d at %0t ns cut into a packet on chan %0d",
                             ch, $time, cur_ch);
                    n_err++;
                end
                if (rem[ch] == 0) begin
                    next_packet(ch, len, test, found);
                    if (found) begin
                        rem[ch]      = len;
                        pkt_len[ch]  = len;
                        pkt_test[ch] = test;
                        words[ch]    = 0;
                        pkt_bad[ch]  = 1'b0;
                    end else begin
                        $display("output word on chan %0d at %0t ns matches no input packet",
                                 ch, $time);
                        n_err++;
                    end
                end
                if (rem[ch] > 0) begin
                    take    = (rem[ch] >= 2) ? 2 : 1;
                    exp_sop = (words[ch] == 0);
                    exp_eop = (rem[ch] <= 2);
                    exp_mty = exp_eop && (take == 1);
                    hi      = 8'h00;
                    next_byte(ch, lo);
                    if (take == 2) begin
                        next_byte(ch, hi);
                    end
                    if (data_d !== {hi, lo} || data_d_sop !== exp_sop ||
                        data_d_eop !== exp_eop || data_d_mty !== exp_mty) begin
                        if (!pkt_bad[ch]) begin
                            $display(
                                "Fail %0t ns: test %0d word %0d exp %h s%b e%b m%b got %h s%b e%b m%b",
                                $time, pkt_test[ch], words[ch], {hi, lo}, exp_sop, exp_eop,
                                exp_mty, data_d, data_d_sop, data_d_eop, data_d_mty);
                        end
                        pkt_bad[ch] = 1'b1;
                    end
                    rem[ch]   -= take;
                    words[ch] += 1;
                    if (rem[ch] == 0) begin
                        if (pkt_bad[ch]) begin
                            n_fail++;
                        end else begin
                            $display("test %0d passed at %0t ns: chan %0d, %0d bytes",
                                     pkt_test[ch], $time, ch, pkt_len[ch]);
                            n_pass++;
                        end
                    end
                    in_pkt = (rem[ch] != 0);
                    cur_ch = ch;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/pkt_merge_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "pkt_merge_cfg.svh"

module pkt_merge_top
    import pkt_merge_pkg::*;
(
    input  logic        rst_n,
    input  logic        clk_a,
    input  logic [7:0]  data_a,
    input  logic        data_a_sop,
    input  logic        data_a_eop,
    input  logic        data_a_vld,
    input  logic        clk_b,
    input  logic [15:0] data_b,
    input  logic        data_b_sop,
    input  logic        data_b_eop,
    input  logic        data_b_mty,
    input  logic        data_b_vld,
    input  logic        clk_c,
    input  logic [31:0] data_c,
    input  logic        data_c_sop,
    input  logic        data_c_eop,
    input  logic [1:0]  data_c_mty,
    input  logic        data_c_vld,
    input  logic        clk_d,
    output logic [15:0] data_d,
    output logic        data_d_sop,
    output logic        data_d_eop,
    output logic        data_d_mty,
    output logic        data_d_vld,
    output logic [1:0]  chan_d
);

    pm_word16_t pk_word;
    pm_word16_t a_rd_word;
    pm_word16_t b_word;
    pm_word16_t b_rd_word;
    pm_word32_t c_word;
    pm_word32_t c_rd_word;
    logic       pk_wr_en;
    logic       pk_end;
    logic       a_empty;
    logic       b_empty;
    logic       c_empty;
    logic       c_pop;
    logic       msg_empty_a;
    logic       msg_empty_b;
    logic       msg_empty_c;
    logic       msg_pop_a;
    logic       msg_pop_b;
    logic       msg_pop_c;

    pkt_word_if #(.DATA_W(16), .MTY_W(1)) a_rd ();
    pkt_word_if #(.DATA_W(16), .MTY_W(1)) b_rd ();
    pkt_word_if #(.DATA_W(16), .MTY_W(1)) c_half ();

    assign b_word = '{sop: data_b_sop, eop: data_b_eop, mty: data_b_mty, data: data_b};
    assign c_word = '{sop: data_c_sop, eop: data_c_eop, mty: data_c_mty, data: data_c};

    byte_packer u_byte_packer (
        .clk_a(clk_a), .rst_n(rst_n), .data_a(data_a), .data_a_sop(data_a_sop),
        .data_a_eop(data_a_eop), .data_a_vld(data_a_vld),
        .wr_en(pk_wr_en), .wr_word(pk_word), .pkt_end(pk_end));

    async_fifo #(.WIDTH($bits(pm_word16_t)), .AW(`PM_DATA_AW)) u_data_fifo_a (
        .wr_clk(clk_a), .rst_n(rst_n), .wr_en(pk_wr_en), .wr_data(pk_word), .full(),
        .rd_clk(clk_d), .rd_en(a_rd.ready && a_rd.valid), .rd_data(a_rd_word),
        .empty(a_empty));

    async_fifo #(.WIDTH(1), .AW(`PM_MSG_AW)) u_msg_fifo_a (
        .wr_clk(clk_a), .rst_n(rst_n), .wr_en(pk_end), .wr_data(1'b1), .full(),
        .rd_clk(clk_d), .rd_en(msg_pop_a), .rd_data(), .empty(msg_empty_a));

    async_fifo #(.WIDTH($bits(pm_word16_t)), .AW(`PM_DATA_AW)) u_data_fifo_b (
        .wr_clk(clk_b), .rst_n(rst_n), .wr_en(data_b_vld), .wr_data(b_word), .full(),
        .rd_clk(clk_d), .rd_en(b_rd.ready && b_rd.valid), .rd_data(b_rd_word),
        .empty(b_empty));

    async_fifo #(.WIDTH(1), .AW(`PM_MSG_AW)) u_msg_fifo_b (
        .wr_clk(clk_b), .rst_n(rst_n), .wr_en(data_b_vld && data_b_eop), .wr_data(1'b1),
        .full(), .rd_clk(clk_d), .rd_en(msg_pop_b), .rd_data(), .empty(msg_empty_b));

    async_fifo #(.WIDTH($bits(pm_word32_t)), .AW(`PM_DATA_AW)) u_data_fifo_c (
        .wr_clk(clk_c), .rst_n(rst_n), .wr_en(data_c_vld), .wr_data(c_word), .full(),
        .rd_clk(clk_d), .rd_en(c_pop), .rd_data(c_rd_word), .empty(c_empty));

    async_fifo #(.WIDTH(1), .AW(`PM_MSG_AW)) u_msg_fifo_c (
        .wr_clk(clk_c), .rst_n(rst_n), .wr_en(data_c_vld && data_c_eop), .wr_data(1'b1),
        .full(), .rd_clk(clk_d), .rd_en(msg_pop_c), .rd_data(), .empty(msg_empty_c));

    // show-ahead read sides of the 16-bit FIFOs.
    assign a_rd.valid = !a_empty;
    assign a_rd.data  = a_rd_word.data;
    assign a_rd.sop   = a_rd_word.sop;
    assign a_rd.eop   = a_rd_word.eop;
    assign a_rd.mty   = a_rd_word.mty;
    assign b_rd.valid = !b_empty;
    assign b_rd.data  = b_rd_word.data;
    assign b_rd.sop   = b_rd_word.sop;
    assign b_rd.eop   = b_rd_word.eop;
    assign b_rd.mty   = b_rd_word.mty;

    word_splitter u_word_splitter (
        .clk_d(clk_d), .rst_n(rst_n), .fifo_word(c_rd_word), .fifo_valid(!c_empty),
        .fifo_pop(c_pop), .half(c_half));

    pkt_merge_arbiter u_pkt_merge_arbiter (
        .clk_d(clk_d), .rst_n(rst_n),
        .pkt_ready_a(!msg_empty_a), .pkt_ready_b(!msg_empty_b), .pkt_ready_c(!msg_empty_c),
        .a_rd(a_rd), .b_rd(b_rd), .c_half(c_half),
        .msg_pop_a(msg_pop_a), .msg_pop_b(msg_pop_b), .msg_pop_c(msg_pop_c),
        .data_d(data_d), .data_d_sop(data_d_sop), .data_d_eop(data_d_eop),
        .data_d_mty(data_d_mty), .data_d_vld(data_d_vld), .chan_d(chan_d));

endmodule

`default_nettype wire

//--- hw/pkt_merge_arbiter.sv
`timescale 1ns/1ns
`default_nettype none
`include "pkt_merge_cfg.svh"

module pkt_merge_arbiter
    import pkt_merge_pkg::*;
(
    input  logic        clk_d,
    input  logic        rst_n,
    input  logic        pkt_ready_a,
    input  logic        pkt_ready_b,
    input  logic        pkt_ready_c,
    pkt_word_if.snk     a_rd,
    pkt_word_if.snk     b_rd,
    pkt_word_if.snk     c_half,
    output logic        msg_pop_a,
    output logic        msg_pop_b,
    output logic        msg_pop_c,
    output logic [15:0] data_d,
    output logic        data_d_sop,
    output logic        data_d_eop,
    output logic        data_d_mty,
    output logic        data_d_vld,
    output pm_chan_e    chan_d
);

    pm_arb_state_e            state;
    pm_chan_e                 grant;
    logic                     sel_valid;
    logic [15:0]              sel_data;
    logic                     sel_sop;
    logic                     sel_eop;
    logic                     sel_mty;
    logic                     accept;
    logic [`PM_DATA_AW+1:0]   beat_cnt;

    assign a_rd.ready   = (state == ARB_XFER) && (grant == CHAN_A);
    assign b_rd.ready   = (state == ARB_XFER) && (grant == CHAN_B);
    assign c_half.ready = (state == ARB_XFER) && (grant == CHAN_C);

    always_comb begin
        case (grant)
            CHAN_A: begin
                sel_valid = a_rd.valid;
                sel_data  = a_rd.data;
                sel_sop   = a_rd.sop;
                sel_eop   = a_rd.eop;
                sel_mty   = a_rd.mty;
            end
            CHAN_B: begin
                sel_valid = b_rd.valid;
                sel_data  = b_rd.data;
                sel_sop   = b_rd.sop;
                sel_eop   = b_rd.eop;
                sel_mty   = b_rd.mty;
            end
            default: begin
                sel_valid = c_half.valid;
                sel_data  = c_half.data;
                sel_sop   = c_half.sop;
                sel_eop   = c_half.eop;
                sel_mty   = c_half.mty;
            end
        endcase
    end

    assign accept    = (state == ARB_XFER) && sel_valid;
    assign msg_pop_a = a_rd.valid && a_rd.ready && a_rd.eop;
    assign msg_pop_b = b_rd.valid && b_rd.ready && b_rd.eop;
    assign msg_pop_c = c_half.valid && c_half.ready && c_half.eop;

    // strict priority, decided only while no packet is in flight.
    always_ff @(posedge clk_d or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            grant <= CHAN_A;
        end else if (state == ARB_IDLE) begin
            if (pkt_ready_a) begin
                state <= ARB_XFER;
                grant <= CHAN_A;
            end else if (pkt_ready_b) begin
                state <= ARB_XFER;
                grant <= CHAN_B;
            end else if (pkt_ready_c) begin
                state <= ARB_XFER;
                grant <= CHAN_C;
            end
        end else if (accept && sel_eop) begin
            state <= ARB_IDLE;
        end
    end

    always_ff @(posedge clk_d or negedge rst_n) begin
        if (!rst_n) begin
            data_d_vld <= 1'b0;
            data_d_sop <= 1'b0;
            data_d_eop <= 1'b0;
            beat_cnt   <= '0;
        end else begin
            data_d_vld <= accept;
            data_d_sop <= accept && sel_sop;
            data_d_eop <= accept && sel_eop;
            if (state == ARB_IDLE) begin
                beat_cnt <= '0;
            end else if (accept) begin
                beat_cnt <= beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_d) begin
        if (accept) begin
            data_d     <= sel_data;
            data_d_mty <= sel_mty;
            chan_d     <= grant;
        end
    end

    a_grant_held: assert property (
        @(posedge clk_d) disable iff (!rst_n)
        (state == ARB_XFER) |=> $stable(grant));

    // a granted packet was complete in its FIFO, so it cannot exceed two halves per entry.
    a_pkt_fits: assert property (
        @(posedge clk_d) disable iff (!rst_n)
        (state == ARB_XFER) |-> (beat_cnt < (2 << `PM_DATA_AW)));

endmodule

`default_nettype wire

//--- hw/word_splitter.sv
`timescale 1ns/1ns
`default_nettype none

module word_splitter
    import pkt_merge_pkg::*;
(
    input  logic       clk_d,
    input  logic       rst_n,
    input  pm_word32_t fifo_word,
    input  logic       fifo_valid,
    output logic       fifo_pop,
    pkt_word_if.src    half
);

    pm_split_state_e state;
    logic            short_last;
    logic            xfer;

    // a last word with two or more empty bytes fits in its low half.
    assign short_last = fifo_word.eop && fifo_word.mty[1];
    assign xfer       = half.valid && half.ready;

    always_comb begin
        half.valid = fifo_valid;
        if (state == SPLIT_LOW) begin
            half.data = fifo_word.data[15:0];
            half.sop  = fifo_word.sop;
            half.eop  = short_last;
            half.mty  = short_last ? fifo_word.mty[0] : 1'b0;
        end else begin
            half.data = fifo_word.data[31:16];
            half.sop  = 1'b0;
            half.eop  = fifo_word.eop;
            half.mty  = fifo_word.mty[0];
        end
    end

    assign fifo_pop = xfer && (state == SPLIT_HIGH || short_last);

    always_ff @(posedge clk_d or negedge rst_n) begin
        if (!rst_n) begin
            state <= SPLIT_LOW;
        end else if (xfer) begin
            if (state == SPLIT_LOW && !short_last) begin
                state <= SPLIT_HIGH;
            end else begin
                state <= SPLIT_LOW;
            end
        end
    end

    a_mty_only_on_eop: assert property (
        @(posedge clk_d) disable iff (!rst_n)
        (xfer && !half.eop) |-> (half.mty == 1'b0));

endmodule

`default_nettype wire

//--- hw/byte_packer.sv
`timescale 1ns/1ns
`default_nettype none

module byte_packer
    import pkt_merge_pkg::*;
(
    input  logic       clk_a,
    input  logic       rst_n,
    input  logic [7:0] data_a,
    input  logic       data_a_sop,
    input  logic       data_a_eop,
    input  logic       data_a_vld,
    output logic       wr_en,
    output pm_word16_t wr_word,
    output logic       pkt_end
);

    logic       byte_cnt;
    logic [7:0] low_byte;
    logic       low_sop;

    // byte_cnt is high while the low lane of a pair is held.
    always_ff @(posedge clk_a or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= 1'b0;
            wr_en    <= 1'b0;
            pkt_end  <= 1'b0;
        end else begin
            wr_en   <= data_a_vld && (byte_cnt || data_a_eop);
            pkt_end <= data_a_vld && data_a_eop;
            if (data_a_vld) begin
                byte_cnt <= !byte_cnt && !data_a_eop;
            end
        end
    end

    always_ff @(posedge clk_a) begin
        if (data_a_vld) begin
            if (!byte_cnt) begin
                low_byte <= data_a;
                low_sop  <= data_a_sop;
                // an eop on the low lane leaves the high byte empty.
                if (data_a_eop) begin
                    wr_word <= '{sop: data_a_sop, eop: 1'b1, mty: 1'b1,
                                 data: {8'h00, data_a}};
                end
            end else begin
                wr_word <= '{sop: low_sop, eop: data_a_eop, mty: 1'b0,
                             data: {data_a, low_byte}};
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/async_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "pkt_merge_cfg.svh"

module async_fifo
    import pkt_merge_pkg::*;
#(
    parameter int WIDTH = $bits(pm_word16_t),
    parameter int AW    = `PM_DATA_AW
) (
    input  logic             wr_clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic [WIDTH-1:0] wr_data,
    output logic             full,
    input  logic             rd_clk,
    input  logic             rd_en,
    output logic [WIDTH-1:0] rd_data,
    output logic             empty
);

    localparam int DEPTH = 1 << AW;

    logic [WIDTH-1:0] mem [DEPTH];

    logic [AW:0] wr_bin;
    logic [AW:0] wr_bin_nxt;
    logic [AW:0] wr_gray;
    logic [AW:0] rd_bin;
    logic [AW:0] rd_bin_nxt;
    logic [AW:0] rd_gray;
    logic [AW:0] rd_gray_w1;
    logic [AW:0] rd_gray_w2;
    logic [AW:0] wr_gray_r1;
    logic [AW:0] wr_gray_r2;
    logic        wr_fire;
    logic        rd_fire;

    assign wr_fire    = wr_en && !full;
    assign rd_fire    = rd_en && !empty;
    assign wr_bin_nxt = wr_bin + {{AW{1'b0}}, wr_fire};
    assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_fire};

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[AW-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin     <= '0;
            wr_gray    <= '0;
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            wr_bin     <= wr_bin_nxt;
            wr_gray    <= wr_bin_nxt ^ (wr_bin_nxt >> 1);
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin     <= '0;
            rd_gray    <= '0;
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            rd_bin     <= rd_bin_nxt;
            rd_gray    <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    // full when the pointers differ in the wrap bit and the next bit in gray form.
    assign full    = (wr_gray == {~rd_gray_w2[AW:AW-1], rd_gray_w2[AW-2:0]});
    assign empty   = (rd_gray == wr_gray_r2);
    assign rd_data = mem[rd_bin[AW-1:0]];

    a_no_overrun: assert property (
        @(posedge wr_clk) disable iff (!rst_n) !(wr_en && full));

    a_no_underrun: assert property (
        @(posedge rd_clk) disable iff (!rst_n) !(rd_en && empty));

endmodule

`default_nettype wire

//--- hw/pkt_word_if.sv
`timescale 1ns/1ns
`default_nettype none

// one packet word stream; a word moves on an edge with valid and ready both high.
interface pkt_word_if #(
    parameter int DATA_W = 16,
    parameter int MTY_W  = 1
);

    logic [DATA_W-1:0] data;
    logic              sop;
    logic              eop;
    logic [MTY_W-1:0]  mty;
    logic              valid;
    logic              ready;

    modport src (output data, sop, eop, mty, valid, input ready);

    modport snk (input data, sop, eop, mty, valid, output ready);

endinterface

`default_nettype wire

//--- hw/pkt_merge_pkg.sv
`default_nettype none

package pkt_merge_pkg;

    typedef enum logic [1:0] {
        CHAN_A = 2'd0,
        CHAN_B = 2'd1,
        CHAN_C = 2'd2
    } pm_chan_e;

    typedef enum logic {
        ARB_IDLE,
        ARB_XFER
    } pm_arb_state_e;

    typedef enum logic {
        SPLIT_LOW,
        SPLIT_HIGH
    } pm_split_state_e;

    // fifo word for channels a and b.
    typedef struct packed {
        logic        sop;
        logic        eop;
        logic        mty;
        logic [15:0] data;
    } pm_word16_t;

    // fifo word for channel c.
    typedef struct packed {
        logic        sop;
        logic        eop;
        logic [1:0]  mty;
        logic [31:0] data;
    } pm_word32_t;

endpackage

`default_nettype wire

//--- include/pkt_merge_cfg.svh
`ifndef PKT_MERGE_CFG_SVH
`define PKT_MERGE_CFG_SVH

// log2 of the data FIFO depth.
// every packet must fit in one data FIFO before it can be granted.
`define PM_DATA_AW 5

// log2 of the message FIFO depth, one entry per buffered packet.
`define PM_MSG_AW 3

`endif
